/* common/line_code_pkg.sv */
`default_nettype none

package line_code_pkg;

	// 8-bit payload byte
	typedef logic [7:0] byte_t;

	// Input character, ctrl set for K codes
	typedef struct packed {
		logic  ctrl;
		byte_t data;
	} char_t;

	// Encoded symbol, bit 0 is "a", bits 9:6 hold the 4b part as j h g f
	typedef logic [9:0] symbol_t;

	// Running disparity, 0 is negative
	typedef logic disp_t;

	typedef logic [31:0] crc_t;

	// Framing characters
	localparam char_t K28_1 = 9'h13C;
	localparam char_t K23_7 = 9'h1F7;
	localparam char_t K28_5 = 9'h1BC;

	// In-band control characters
	localparam char_t K28_0 = 9'h11C;
	localparam char_t K28_2 = 9'h15C;
	localparam char_t K28_3 = 9'h17C;
	localparam char_t K28_4 = 9'h19C;
	localparam char_t K28_6 = 9'h1DC;
	localparam char_t K28_7 = 9'h1FC;
	localparam char_t K27_7 = 9'h1FB;
	localparam char_t K29_7 = 9'h1FD;
	localparam char_t K30_7 = 9'h1FE;

	// CRC-32, reflected form of 0x04C11DB7
	localparam crc_t CRC_INIT      = 32'hFFFF_FFFF;
	localparam crc_t CRC_POLY_REFL = 32'hEDB8_8320;
	localparam crc_t CRC_XOR_OUT   = 32'hFFFF_FFFF;

	// CRC bytes sent after K23.7, lowest byte first
	localparam int CRC_BYTES = 4;

endpackage

`default_nettype wire

/* encoder/symbol_encoder.sv */
`timescale 1ns/100ps
`default_nettype none

module symbol_encoder import line_code_pkg::*; (
	input  char_t   char,
	input  disp_t   disp,
	output symbol_t symbol,
	output disp_t   disp_next,
	output logic    known
);

	logic [4:0] x;
	logic [2:0] y;
	logic [5:0] six_neg;
	logic [5:0] six;
	logic [3:0] four_neg;
	logic [3:0] four;
	disp_t      disp6;
	logic       alt7;
	symbol_t    k_neg;
	logic       k_hit;
	symbol_t    data_sym;
	int         ones;

	assign x = char.data[4:0];
	assign y = char.data[7:5];

	// 5b/6b table, codes for negative disparity
	always_comb begin
		case (x)
			5'd0: six_neg = 6'b111001;
			5'd1: six_neg = 6'b101110;
			5'd2: six_neg = 6'b101101;
			5'd3: six_neg = 6'b100011;
			5'd4: six_neg = 6'b101011;
			5'd5: six_neg = 6'b100101;
			5'd6: six_neg = 6'b100110;
			5'd7: six_neg = 6'b000111;
			5'd8: six_neg = 6'b100111;
			5'd9: six_neg = 6'b101001;
			5'd10: six_neg = 6'b101010;
			5'd11: six_neg = 6'b001011;
			5'd12: six_neg = 6'b101100;
			5'd13: six_neg = 6'b001101;
			5'd14: six_neg = 6'b001110;
			5'd15: six_neg = 6'b111010;
			5'd16: six_neg = 6'b110110;
			5'd17: six_neg = 6'b110001;
			5'd18: six_neg = 6'b110010;
			5'd19: six_neg = 6'b010011;
			5'd20: six_neg = 6'b110100;
			5'd21: six_neg = 6'b010101;
			5'd22: six_neg = 6'b010110;
			5'd23: six_neg = 6'b010111;
			5'd24: six_neg = 6'b110011;
			5'd25: six_neg = 6'b011001;
			5'd26: six_neg = 6'b011010;
			5'd27: six_neg = 6'b011011;
			5'd28: six_neg = 6'b011100;
			5'd29: six_neg = 6'b011101;
			5'd30: six_neg = 6'b011110;
			default: six_neg = 6'b110101;
		endcase

		// Unbalanced codes and D.7 flip at positive disparity
		if (disp && (($countones(six_neg) != 3) || (x == 5'd7)))
			six = ~six_neg;
		else
			six = six_neg;

		if ($countones(six) == 4)
			disp6 = 1'b1;
		else if ($countones(six) == 2)
			disp6 = 1'b0;
		else
			disp6 = disp;
	end

	// A7 avoids a run of five equal bits across the 6b/4b boundary
	assign alt7 = (!disp6 && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
		(disp6 && (x == 5'd11 || x == 5'd13 || x == 5'd14));

	// 3b/4b table, chosen by disparity after the 6b block
	always_comb begin
		case (y)
			3'd0: four_neg = 4'b1101;
			3'd1: four_neg = 4'b1001;
			3'd2: four_neg = 4'b1010;
			3'd3: four_neg = 4'b0011;
			3'd4: four_neg = 4'b1011;
			3'd5: four_neg = 4'b0101;
			3'd6: four_neg = 4'b0110;
			default: four_neg = alt7 ? 4'b1110 : 4'b0111;
		endcase

		if (disp6 && (($countones(four_neg) != 2) || (y == 3'd3)))
			four = ~four_neg;
		else
			four = four_neg;
	end

	assign data_sym = {four, six};

	// Control symbols at negative disparity, the positive form is the complement
	always_comb begin
		k_hit = 1'b1;
		case (char)
			K28_0: k_neg = 10'b0010111100;
			K28_1: k_neg = 10'b1001111100;
			K28_2: k_neg = 10'b1010111100;
			K28_3: k_neg = 10'b1100111100;
			K28_4: k_neg = 10'b0100111100;
			K28_5: k_neg = 10'b0101111100;
			K28_6: k_neg = 10'b0110111100;
			K28_7: k_neg = 10'b0001111100;
			K23_7: k_neg = 10'b0001010111;
			K27_7: k_neg = 10'b0001011011;
			K29_7: k_neg = 10'b0001011101;
			K30_7: k_neg = 10'b0001011110;
			default: begin
				k_neg = '0;
				k_hit = 1'b0;
			end
		endcase
	end

	always_comb begin
		if (!char.ctrl)
			symbol = data_sym;
		else if (k_hit)
			symbol = disp ? ~k_neg : k_neg;
		else
			symbol = '0;
	end

	assign known = !char.ctrl || k_hit;

	// Unbalanced symbols flip the running disparity
	assign ones = $countones(symbol);
	assign disp_next = (ones == 4 || ones == 6) ? ~disp : disp;

endmodule

`default_nettype wire

/* rtl/frame_crc.sv */
`timescale 1ns/100ps
`default_nettype none

module frame_crc import line_code_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  clear,
	input  logic  push,
	input  byte_t data,
	output crc_t  crc_value
);

	crc_t crc_reg;

	// One byte through the reflected register, LSB first
	function automatic crc_t crc_fold(input crc_t crc, input byte_t value);
		crc_t c;
		c = crc ^ {24'd0, value};
		for (int i = 0; i < 8; i++) begin
			if (c[0])
				c = (c >> 1) ^ CRC_POLY_REFL;
			else
				c = c >> 1;
		end
		return c;
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			crc_reg <= CRC_INIT;
		end else if (clear) begin
			crc_reg <= CRC_INIT;
		end else if (push) begin
			crc_reg <= crc_fold(crc_reg, data);
		end
	end

	// Finished value, ready to send
	assign crc_value = crc_reg ^ CRC_XOR_OUT;

endmodule

`default_nettype wire

/* rtl/frame_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module frame_sequencer import line_code_pkg::*; #(
	parameter int SYNC_COUNT = 4
) (
	input  logic    clk,
	input  logic    reset,
	input  logic    pushin,
	input  logic    startin,
	input  char_t   datain,
	input  symbol_t enc_symbol,
	input  disp_t   enc_disp_next,
	input  logic    enc_known,
	input  crc_t    crc_value,
	output char_t   enc_char,
	output disp_t   enc_disp,
	output logic    crc_clear,
	output logic    crc_push,
	output logic    pushout,
	output logic    startout,
	output symbol_t dataout
);

	localparam int SYNC_W = $clog2(SYNC_COUNT);
	localparam int CRC_W = $clog2(CRC_BYTES);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SYNC,
		ST_BODY,
		ST_CRC,
		ST_CLOSE
	} state_t;

	state_t           state;
	state_t           state_next;
	logic [SYNC_W-1:0] sync_cnt;
	logic [SYNC_W-1:0] sync_cnt_next;
	logic [CRC_W-1:0]  crc_cnt;
	logic [CRC_W-1:0]  crc_cnt_next;
	disp_t            disp;
	logic             emit;
	logic             emit_start;
	logic             in_band;

	assign enc_disp = disp;

	// Sync and close characters are not accepted inside the body
	assign in_band = datain.ctrl && enc_known && (datain != K28_1) && (datain != K28_5);

	always_comb begin
		state_next = state;
		sync_cnt_next = sync_cnt;
		crc_cnt_next = crc_cnt;
		enc_char = datain;
		emit = 1'b0;
		emit_start = 1'b0;
		crc_clear = 1'b0;
		crc_push = 1'b0;

		case (state)
			ST_IDLE: begin
				if (pushin && startin && datain == K28_1) begin
					emit = 1'b1;
					emit_start = 1'b1;
					crc_clear = 1'b1;
					sync_cnt_next = SYNC_W'(1);
					state_next = ST_SYNC;
				end
			end
			ST_SYNC: begin
				if (pushin) begin
					if (datain == K28_1) begin
						emit = 1'b1;
						if (sync_cnt == SYNC_W'(SYNC_COUNT - 1))
							state_next = ST_BODY;
						else
							sync_cnt_next = sync_cnt + 1'b1;
					end else begin
						// Broken sync, drop the frame silently
						state_next = ST_IDLE;
					end
				end
			end
			ST_BODY: begin
				if (pushin) begin
					if (!datain.ctrl) begin
						emit = 1'b1;
						crc_push = 1'b1;
					end else if (datain == K23_7) begin
						emit = 1'b1;
						crc_cnt_next = '0;
						state_next = ST_CRC;
					end else if (in_band) begin
						emit = 1'b1;
					end
				end
			end
			ST_CRC: begin
				// CRC bytes go out as ordinary data, lowest first
				enc_char = '{ctrl: 1'b0, data: crc_value[{crc_cnt, 3'b000} +: 8]};
				emit = 1'b1;
				if (crc_cnt == CRC_W'(CRC_BYTES - 1)) begin
					crc_cnt_next = '0;
					state_next = ST_CLOSE;
				end else begin
					crc_cnt_next = crc_cnt + 1'b1;
				end
			end
			ST_CLOSE: begin
				enc_char = K28_5;
				emit = 1'b1;
				state_next = ST_IDLE;
			end
			default: state_next = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			sync_cnt <= '0;
			crc_cnt <= '0;
			disp <= 1'b0;
			pushout <= 1'b0;
			startout <= 1'b0;
			dataout <= '0;
		end else begin
			state <= state_next;
			sync_cnt <= sync_cnt_next;
			crc_cnt <= crc_cnt_next;
			pushout <= emit;
			startout <= emit_start;
			// Disparity moves only with a symbol on the line
			if (emit) begin
				dataout <= enc_symbol;
				disp <= enc_disp_next;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/line_framer.sv */
`timescale 1ns/100ps
`default_nettype none

module line_framer import line_code_pkg::*; #(
	parameter int SYNC_COUNT = 4
) (
	input  logic    clk,
	input  logic    reset,
	input  logic    pushin,
	input  logic    startin,
	input  char_t   datain,
	output logic    pushout,
	output logic    startout,
	output symbol_t dataout
);

	char_t   enc_char;
	disp_t   enc_disp;
	symbol_t enc_symbol;
	disp_t   enc_disp_next;
	logic    enc_known;
	logic    crc_clear;
	logic    crc_push;
	crc_t    crc_value;

	frame_sequencer #(
		.SYNC_COUNT(SYNC_COUNT)
	) u_sequencer (
		.clk          (clk),
		.reset        (reset),
		.pushin       (pushin),
		.startin      (startin),
		.datain       (datain),
		.enc_symbol   (enc_symbol),
		.enc_disp_next(enc_disp_next),
		.enc_known    (enc_known),
		.crc_value    (crc_value),
		.enc_char     (enc_char),
		.enc_disp     (enc_disp),
		.crc_clear    (crc_clear),
		.crc_push     (crc_push),
		.pushout      (pushout),
		.startout     (startout),
		.dataout      (dataout)
	);

	symbol_encoder u_encoder (
		.char     (enc_char),
		.disp     (enc_disp),
		.symbol   (enc_symbol),
		.disp_next(enc_disp_next),
		.known    (enc_known)
	);

	// CRC sees the raw input byte, the sequencer decides when it counts
	frame_crc u_crc (
		.clk      (clk),
		.reset    (reset),
		.clear    (crc_clear),
		.push     (crc_push),
		.data     (datain.data),
		.crc_value(crc_value)
	);

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
	parameter int CLK_PERIOD   = 10,
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Reset drops on a falling edge, clear of the sampling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

/* dv/line_framer_ref.svh */
`ifndef LINE_FRAMER_REF_SVH
`define LINE_FRAMER_REF_SVH

// Code tables written in line order, first bit on the left (abcdei and fghj), RD- column
localparam logic [5:0] SIX_RDN [32] = '{
	6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
	6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
	6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
	6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
};
localparam logic [3:0] FOUR_RDN [8] = '{
	4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
};

function automatic int ones_in(input logic [9:0] v);
	int n;
	n = 0;
	for (int k = 0; k < 10; k++)
		n += v[k];
	return n;
endfunction

// Line order to symbol_t, bit a lands in bit 0
function automatic symbol_t line_to_symbol(input logic [9:0] line);
	symbol_t s;
	for (int k = 0; k < 10; k++)
		s[k] = line[9-k];
	return s;
endfunction

function automatic symbol_t ref_encode(input char_t c, input disp_t rd, output disp_t rd_next);
	logic [9:0] k;
	logic [5:0] c6;
	logic [3:0] c4;
	disp_t      rd6;
	logic       use_a7;
	int         x;
	int         y;
	if (c.ctrl) begin
		case (c)
			K28_0: k = 10'b001111_0100;
			K28_1: k = 10'b001111_1001;
			K28_2: k = 10'b001111_0101;
			K28_3: k = 10'b001111_0011;
			K28_4: k = 10'b001111_0010;
			K28_5: k = 10'b001111_1010;
			K28_6: k = 10'b001111_0110;
			K28_7: k = 10'b001111_1000;
			K23_7: k = 10'b111010_1000;
			K27_7: k = 10'b110110_1000;
			K29_7: k = 10'b101110_1000;
			K30_7: k = 10'b011110_1000;
			default: k = '0;
		endcase
		if (rd)
			k = ~k;
		rd_next = (ones_in(k) == 5) ? rd : ~rd;
		return line_to_symbol(k);
	end
	x = int'(c.data[4:0]);
	y = int'(c.data[7:5]);
	c6 = SIX_RDN[x];
	if (rd && (ones_in({4'b0, c6}) != 3 || x == 7))
		c6 = ~c6;
	rd6 = (ones_in({4'b0, c6}) != 3) ? ~rd : rd;
	use_a7 = (!rd6 && (x == 17 || x == 18 || x == 20)) ||
		(rd6 && (x == 11 || x == 13 || x == 14));
	c4 = (y == 7 && use_a7) ? 4'b0111 : FOUR_RDN[y];
	if (rd6 && (ones_in({6'b0, c4}) != 2 || y == 3))
		c4 = ~c4;
	rd_next = (ones_in({6'b0, c4}) != 2) ? ~rd6 : rd6;
	return line_to_symbol({c6, c4});
endfunction

// Bit-serial reflected CRC-32, LSB of the byte first
function automatic crc_t ref_crc_byte(input crc_t crc, input byte_t b);
	crc_t r;
	logic fb;
	r = crc;
	for (int k = 0; k < 8; k++) begin
		fb = r[0] ^ b[k];
		r = r >> 1;
		if (fb)
			r = r ^ CRC_POLY_REFL;
	end
	return r;
endfunction

`endif

/* dv/line_framer_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module line_framer_tb import line_code_pkg::*; ();

	localparam int CLK_PERIOD = 10;
	localparam int SYNC = 4;
	// Characters driven by each test, start 7, data 64, control 12, end 1, resync 19
	localparam int TOTAL_CHARS = 7 + 64 + 12 + 1 + 19;
	localparam int WATCHDOG_CYCLES = 40 * TOTAL_CHARS + 200;

	logic    clk;
	logic    reset;
	logic    pushin;
	logic    startin;
	char_t   datain;
	logic    pushout;
	logic    startout;
	symbol_t dataout;

	symbol_t exp_sym[$];
	logic    exp_start[$];
	byte_t   frame_bytes[$];
	disp_t   tb_disp;
	int      seed;
	int      sym_errors;
	int      flag_errors;
	int      other_errors;

	`include "line_framer_ref.svh"

	localparam char_t IN_BAND [9] = '{K28_0, K28_2, K28_3, K28_4, K28_6, K28_7, K27_7, K29_7, K30_7};

	tb_clock #(.CLK_PERIOD(CLK_PERIOD), .RESET_CYCLES(5)) u_clock (.clk(clk), .reset(reset));

	line_framer #(.SYNC_COUNT(SYNC)) dut (
		.clk     (clk),
		.reset   (reset),
		.pushin  (pushin),
		.startin (startin),
		.datain  (datain),
		.pushout (pushout),
		.startout(startout),
		.dataout (dataout)
	);

	task automatic check_symbol(input symbol_t got, input symbol_t exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t: %s symbol %h, expected %h", $time, what, got, exp);
			sym_errors++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
			flag_errors++;
		end
	endtask

	function automatic void expect_char(input char_t c, input logic start);
		disp_t nd;
		exp_sym.push_back(ref_encode(c, tb_disp, nd));
		exp_start.push_back(start);
		tb_disp = nd;
	endfunction

	task automatic push_char(input char_t c, input logic start);
		@(negedge clk);
		pushin = 1'b1;
		startin = start;
		datain = c;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			pushin = 1'b0;
			startin = 1'b0;
			datain = '0;
		end
	endtask

	task automatic send_sync();
		push_char(K28_1, 1'b1);
		expect_char(K28_1, 1'b1);
		frame_bytes.delete();
		repeat (SYNC - 1) begin
			push_char(K28_1, 1'b0);
			expect_char(K28_1, 1'b0);
		end
	endtask

	task automatic send_data(input byte_t b);
		push_char({1'b0, b}, 1'b0);
		expect_char({1'b0, b}, 1'b0);
		frame_bytes.push_back(b);
	endtask

	task automatic test_start_sequence();
		push_char({1'b0, 8'h55}, 1'b0);
		push_char(K28_1, 1'b0);
		push_char({1'b0, 8'hBC}, 1'b1);
		idle_cycles(2);
		send_sync();
	endtask

	task automatic test_data_encoding();
		repeat (64) send_data(byte_t'($random(seed)));
	endtask

	task automatic test_control_chars();
		foreach (IN_BAND[i]) begin
			push_char(IN_BAND[i], 1'b0);
			expect_char(IN_BAND[i], 1'b0);
		end
		// Outside the in-band list, nothing goes out
		push_char(9'h1AA, 1'b0);
		push_char(K28_1, 1'b0);
		push_char(K28_5, 1'b0);
	endtask

	task automatic test_frame_end();
		crc_t crc;
		push_char(K23_7, 1'b0);
		expect_char(K23_7, 1'b0);
		crc = CRC_INIT;
		foreach (frame_bytes[i])
			crc = ref_crc_byte(crc, frame_bytes[i]);
		crc = crc ^ CRC_XOR_OUT;
		for (int i = 0; i < CRC_BYTES; i++)
			expect_char({1'b0, crc[8*i +: 8]}, 1'b0);
		expect_char(K28_5, 1'b0);
		// K23.7, four CRC bytes and K28.5 back to back
		repeat (6) begin
			@(negedge clk);
			pushin = 1'b0;
			check_flag(pushout, 1'b1, "pushout during frame end");
		end
		idle_cycles(2);
	endtask

	task automatic test_broken_sync_and_gaps();
		push_char(K28_1, 1'b1);
		expect_char(K28_1, 1'b1);
		push_char(K28_1, 1'b0);
		expect_char(K28_1, 1'b0);
		push_char({1'b0, 8'h3C}, 1'b0);
		push_char({1'b0, 8'h5A}, 1'b0);
		idle_cycles(1);
		send_sync();
		for (int i = 0; i < 10; i++) begin
			send_data(byte_t'($random(seed)));
			if (i % 3 == 0)
				idle_cycles(i % 4 + 1);
		end
		test_frame_end();
	endtask

	always @(negedge clk) begin
		if (!reset && pushout) begin
			if (exp_sym.size() == 0) begin
				$display("Symbol %h came out at %0t with nothing expected", dataout, $time);
				other_errors++;
			end else begin
				check_symbol(dataout, exp_sym.pop_front(), "output");
				check_flag(startout, exp_start.pop_front(), "startout");
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		pushin = 1'b0;
		startin = 1'b0;
		datain = '0;
		seed = 32'hac3a_0e38;
		tb_disp = 1'b0;
		sym_errors = 0;
		flag_errors = 0;
		other_errors = 0;
		wait (!reset);
		test_start_sequence();
		test_data_encoding();
		test_control_chars();
		test_frame_end();
		test_broken_sync_and_gaps();
		for (int i = 0; i < 20 && exp_sym.size() > 0; i++)
			@(negedge clk);
		if (exp_sym.size() != 0) begin
			$display("%0d expected symbols never came out", exp_sym.size());
			other_errors += exp_sym.size();
		end
		$display("Errors: symbol %0d, flag %0d, other %0d", sym_errors, flag_errors, other_errors);
		if (sym_errors + flag_errors + other_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+dv
common/line_code_pkg.sv
encoder/symbol_encoder.sv
rtl/frame_crc.sv
rtl/frame_sequencer.sv
rtl/line_framer.sv
dv/tb_clock.sv
dv/line_framer_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module line_framer_tb -f src.f -o line_framer_sim
out=$(./obj_dir/line_framer_sim)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "Test OK"; then
	exit 0
fi
exit 1
